// File: Bender.yml
package:
  name: ec_alu

sources:
  - verilog/ec_alu_pkg.sv
  - verilog/mod_addsub.sv
  - verilog/mod_mul.sv
  - verilog/alu_seq.sv
  - verilog/apb_regs.sv
  - verilog/ec_alu_top.sv
  - target: test
    files:
      - test/ec_alu_sva.sv
      - test/tb_ec_alu.sv

// File: project.f
verilog/ec_alu_pkg.sv
verilog/mod_addsub.sv
verilog/mod_mul.sv
verilog/alu_seq.sv
verilog/apb_regs.sv
verilog/ec_alu_top.sv
test/ec_alu_sva.sv
test/tb_ec_alu.sv

// File: test/ec_alu_sva.sv
`timescale 1ns/10ps

module ec_alu_sva (
	input logic clk,
	input logic rst,
	input logic busy,
	input logic we_x,
	input logic we_y,
	input logic we_a,
	input logic we_b,
	input logic we_t,
	input logic mul_start,
	input logic mul_done
);

	logic mul_pending;	// Product in flight

	always_ff @(posedge clk) begin
		if (rst) begin
			mul_pending <= 1'b0;
		end else if (mul_start) begin
			mul_pending <= 1'b1;
		end else if (mul_done) begin
			mul_pending <= 1'b0;
		end
	end

	// A new product may only start once the previous one completes
	start_when_free: assert property (@(posedge clk) disable iff (rst)
		mul_start |-> (!mul_pending || mul_done))
		else $error("mul_start while a product is still pending");

	we_only_when_busy: assert property (@(posedge clk) disable iff (rst)
		(we_x || we_y || we_a || we_b || we_t) |-> busy)
		else $error("register write-back while the sequencer is idle");

	done_after_start: assert property (@(posedge clk) disable iff (rst)
		mul_done |-> mul_pending)
		else $error("mul_done without a preceding mul_start");

endmodule

bind ec_alu_top ec_alu_sva sva0 (
	.clk, .rst, .busy,
	.we_x, .we_y, .we_a, .we_b, .we_t, .mul_start, .mul_done
);

// File: test/tb_ec_alu.sv
`timescale 1ns/10ps

module tb_ec_alu
	import ec_alu_pkg::*;
;

	localparam int W = 255;
	localparam logic [511:0] QW = (512'd1 << 255) - 512'd19;	// Field prime, wide
	localparam logic [W-1:0] Q = QW[W-1:0];
	localparam int POLL_LIMIT = 1000;	// Status reads per operation

	logic clk, rst, psel, penable, pwrite, pready, pslverr, err;
	logic [7:0] paddr;
	logic [31:0] pwdata, prdata, data, exp_w, got_w;
	logic [W-1:0] mx, my, ma, mb, mt, md, v;	// Expected register contents
	logic [31:0] exp_q[$];
	logic [31:0] got_q[$];
	string msg_q[$];
	string cmp_msg;
	integer seed;
	int mismatches, timeouts, i, drain;

	ec_alu_top dut0 (
		.clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata,
		.prdata, .pready, .pslverr
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [W-1:0] sum_q(input logic [W-1:0] a, input logic [W-1:0] b);
		logic [511:0] t;
		t = (512'(a) + 512'(b)) % QW;
		return t[W-1:0];
	endfunction

	function automatic logic [W-1:0] diff_q(input logic [W-1:0] a, input logic [W-1:0] b);
		logic [511:0] t;
		t = (512'(a) + QW - 512'(b)) % QW;
		return t[W-1:0];
	endfunction

	function automatic logic [W-1:0] prod_q(input logic [W-1:0] a, input logic [W-1:0] b);
		logic [511:0] t;
		t = (512'(a) * 512'(b)) % QW;
		return t[W-1:0];
	endfunction

	function automatic logic [W-1:0] force_even(input logic [W-1:0] p);
		return p[0] ? Q - p : p;	// Q is odd, so Q - p is even
	endfunction

	function automatic logic [W-1:0] random_operand();
		logic [511:0] t;
		int k;
		t = '0;
		for (k = 0; k < 8; k++) t = {t[479:0], 32'($random(seed))};
		t = t % QW;
		return t[W-1:0];
	endfunction

	task automatic transfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic slverr);
		@(posedge clk);
		#5;
		psel = 1'b1;	// Setup phase
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = wdata;
		@(posedge clk);
		#5;
		penable = 1'b1;
		#40;
		rdata = prdata;	// Mid access phase
		slverr = pslverr;
		check_bit(pready, 1'b1, "pready in access phase");
		@(posedge clk);
		#5;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			mismatches++;
			$display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic queue_word(input logic [31:0] exp, input logic [31:0] got,
		input string what);
		exp_q.push_back(exp);
		got_q.push_back(got);
		msg_q.push_back(what);
	endtask

	task automatic load_value(input logic [2:0] region, input logic [W-1:0] value);
		logic [255:0] vv;
		logic [31:0] rd;
		logic se;
		int w;
		vv = {1'b0, value};
		for (w = 0; w < 8; w++) begin
			transfer(1'b1, {region, 3'(w), 2'b00}, vv[w*32 +: 32], rd, se);
			check_bit(se, 1'b0, "pslverr on operand write");
		end
		case (region)
			REG_X: mx = value;
			REG_Y: my = value;
			REG_A: ma = value;
			REG_B: mb = value;
			REG_T: mt = value;
			default: md = value;
		endcase
	endtask

	task automatic fetch_check(input logic [2:0] region, input logic [W-1:0] exp,
		input string what);
		logic [255:0] ev;
		logic [31:0] rd;
		logic se;
		int w;
		ev = {1'b0, exp};
		for (w = 0; w < 8; w++) begin
			transfer(1'b0, {region, 3'(w), 2'b00}, 32'd0, rd, se);
			check_bit(se, 1'b0, "pslverr on read");
			queue_word(ev[w*32 +: 32], rd,
				$sformatf("%s region %0d word %0d", what, region, w));
		end
	endtask

	task automatic check_all(input string what);
		fetch_check(REG_X, mx, what);
		fetch_check(REG_Y, my, what);
		fetch_check(REG_A, ma, what);
		fetch_check(REG_B, mb, what);
		fetch_check(REG_T, mt, what);
		fetch_check(REG_D, md, what);
	endtask

	task automatic start_op(input alu_op_e op);
		logic [31:0] rd;
		logic se;
		transfer(1'b1, {REG_CTRL, 5'd0}, 32'(op), rd, se);
		check_bit(se, 1'b0, "pslverr on command");
	endtask

	task automatic wait_idle();
		logic [31:0] rd;
		logic se;
		int polls;
		polls = 0;
		rd = 32'd1;
		while (rd[0] && polls < POLL_LIMIT) begin
			transfer(1'b0, {REG_CTRL, 5'd0}, 32'd0, rd, se);
			polls++;
		end
		if (rd[0]) begin
			timeouts++;
			$display("Timeout: busy still set after %0d status reads", polls);
		end
	endtask

	task automatic reject_while_busy();
		logic [31:0] rd;
		logic se;
		transfer(1'b1, {REG_CTRL, 5'd0}, 32'(OP_DIVMUL), rd, se);
		check_bit(se, 1'b1, "pslverr on command while busy");
		transfer(1'b1, {REG_X, 5'd0}, 32'h1234_5678, rd, se);
		check_bit(se, 1'b1, "pslverr on operand write while busy");
		transfer(1'b0, {REG_CTRL, 5'd0}, 32'd0, rd, se);
		check_bit(rd[0], 1'b1, "busy flag during operation");
	endtask

	task automatic run_precal(input logic [W-1:0] a, input logic [W-1:0] b,
		input logic [W-1:0] d, input logic poke, input string what);
		load_value(REG_A, a);
		load_value(REG_B, b);
		load_value(REG_D, d);
		start_op(OP_PRECAL);
		if (poke) reject_while_busy();
		wait_idle();
		ma = diff_q(b, a);
		mb = sum_q(a, b);
		mt = prod_q(prod_q(a, b), d);
		check_all(what);
	endtask

	task automatic run_divmul(input logic [W-1:0] x, input logic [W-1:0] y,
		input logic [W-1:0] a, input string what);
		load_value(REG_X, x);
		load_value(REG_Y, y);
		load_value(REG_A, a);
		start_op(OP_DIVMUL);
		wait_idle();
		mx = force_even(prod_q(a, x));	// r = A for both products
		my = force_even(prod_q(a, y));
		check_all(what);
	endtask

	// Compare process, one queued word per entry
	always @(posedge clk) begin
		while (exp_q.size() > 0) begin
			exp_w = exp_q.pop_front();
			got_w = got_q.pop_front();
			cmp_msg = msg_q.pop_front();
			if (got_w !== exp_w) begin
				mismatches++;
				$display("MISMATCH at %0t: %s read %h, expected %h",
					$time, cmp_msg, got_w, exp_w);
			end
		end
	end

	initial begin
		seed = 32'hb1e717d7;
		mismatches = 0;
		timeouts = 0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		{mx, my, ma, mb, mt, md} = '0;
		rst = 1'b1;
		repeat (2) @(posedge clk);
		#5;
		rst = 1'b0;

		check_all("after reset");
		fetch_check(REG_CTRL, '0, "status after reset");
		for (i = 0; i < 6; i++) load_value(3'(i), random_operand());
		check_all("register access");
		transfer(1'b1, {REG_X, 3'd7, 2'b00}, 32'hffff_ffff, data, err);	// Bit 255 is beyond W
		mx[W-1:224] = '1;
		check_all("top word");

		for (i = 0; i < 3; i++) begin
			run_precal(random_operand(), random_operand(), random_operand(), 1'b0,
				"precal");
			run_divmul(random_operand(), random_operand(), random_operand(), "divmul");
		end
		run_precal(random_operand(), random_operand(), random_operand(), 1'b1, "rejection");

		transfer(1'b1, 8'he0, 32'hdead_beef, data, err);	// Region 7
		check_bit(err, 1'b1, "pslverr on region 7 write");
		transfer(1'b0, 8'he4, 32'd0, data, err);
		check_bit(err, 1'b1, "pslverr on region 7 read");
		queue_word(32'd0, data, "region 7 read data");

		// Edge operands
		run_precal('0, Q - 1'b1, 255'd1, 1'b0, "precal zero");
		run_precal(Q - 1'b1, Q - 1'b1, Q - 1'b1, 1'b0, "precal product one");
		v = random_operand();
		run_precal(v, v, '0, 1'b0, "precal equal");
		run_divmul(Q - 1'b1, '0, 255'd1, "divmul one");
		run_divmul(255'd1, Q - 1'b1, Q - 1'b1, "divmul top");

		drain = 0;
		while (exp_q.size() > 0 && drain < 10) begin
			@(posedge clk);
			drain++;
		end
		if (exp_q.size() > 0) begin
			timeouts++;
			$display("Timeout: compare queue did not drain");
		end

		$display("Errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// File: verilog/alu_seq.sv
`timescale 1ns/10ps

module alu_seq
	import ec_alu_pkg::*;
#(
	parameter int W = 255,
	parameter logic [W-1:0] Q = {W{1'b1}} - 18
) (
	input  logic clk,
	input  logic rst,
	input  logic start,
	input  alu_op_e op,
	output logic busy,
	input  logic [W-1:0] reg_x,
	input  logic [W-1:0] reg_y,
	input  logic [W-1:0] reg_a,
	input  logic [W-1:0] reg_b,
	input  logic [W-1:0] reg_t,
	input  logic [W-1:0] reg_d,
	output logic we_x,
	output logic we_y,
	output logic we_a,
	output logic we_b,
	output logic we_t,
	output logic [W-1:0] wr_x,
	output logic [W-1:0] wr_y,
	output logic [W-1:0] wr_a,
	output logic [W-1:0] wr_b,
	output logic [W-1:0] wr_t,
	output logic mul_start,
	output logic [W-1:0] mul_a,
	output logic [W-1:0] mul_b,
	input  logic [W-1:0] mul_p,
	input  logic mul_done,
	output logic [W-1:0] as,
	output logic [W-1:0] bs,
	input  logic [W-1:0] sum,
	input  logic [W-1:0] diff
);

	alu_state_e state, state_nxt;
	logic [W-1:0] even_p;	// Product forced even

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		mul_start = 1'b0;
		mul_a = reg_a;	// r = A in both operations
		mul_b = reg_b;
		as = reg_b;	// diff gives B - A, sum gives A + B
		bs = reg_a;
		{we_x, we_y, we_a, we_b, we_t} = '0;
		case (state)
			ST_IDLE: begin
				if (start && op == OP_PRECAL) begin
					state_nxt = ST_PRE_ADD;
				end else if (start && op == OP_DIVMUL) begin
					state_nxt = ST_DM_MUL_X;
					mul_start = 1'b1;
					mul_b = reg_x;
				end
			end
			ST_PRE_ADD: begin
				we_a = 1'b1;
				we_b = 1'b1;
				mul_start = 1'b1;	// Captures old A and B on this edge
				state_nxt = ST_PRE_MUL_AB;
			end
			ST_PRE_MUL_AB: begin
				if (mul_done) begin
					mul_start = 1'b1;
					mul_a = mul_p;
					mul_b = reg_d;
					state_nxt = ST_PRE_MUL_D;
				end
			end
			ST_PRE_MUL_D: begin
				we_t = mul_done;
				if (mul_done) state_nxt = ST_IDLE;
			end
			ST_DM_MUL_X: begin
				as = Q;	// Q - p for odd products
				bs = mul_p;
				if (mul_done) begin
					we_x = 1'b1;
					mul_start = 1'b1;
					mul_b = reg_y;
					state_nxt = ST_DM_MUL_Y;
				end
			end
			ST_DM_MUL_Y: begin
				as = Q;
				bs = mul_p;
				we_y = mul_done;
				if (mul_done) state_nxt = ST_IDLE;
			end
			default: state_nxt = ST_IDLE;
		endcase
	end

	assign busy = (state != ST_IDLE);
	assign even_p = mul_p[0] ? diff : mul_p;

	// Write ports carry the next register value
	assign wr_x = we_x ? even_p : reg_x;
	assign wr_y = we_y ? even_p : reg_y;
	assign wr_a = we_a ? diff : reg_a;
	assign wr_b = we_b ? sum : reg_b;
	assign wr_t = we_t ? mul_p : reg_t;

endmodule

// File: verilog/apb_regs.sv
`timescale 1ns/10ps

module apb_regs
	import ec_alu_pkg::*;
#(
	parameter int W = 255
) (
	input  logic clk,
	input  logic rst,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [APB_AW-1:0] paddr,
	input  logic [APB_DW-1:0] pwdata,
	output logic [APB_DW-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic start,
	output alu_op_e op,
	input  logic busy,
	output logic [W-1:0] reg_x,
	output logic [W-1:0] reg_y,
	output logic [W-1:0] reg_a,
	output logic [W-1:0] reg_b,
	output logic [W-1:0] reg_t,
	output logic [W-1:0] reg_d,
	input  logic we_x,
	input  logic we_y,
	input  logic we_a,
	input  logic we_b,
	input  logic we_t,
	input  logic [W-1:0] wr_x,
	input  logic [W-1:0] wr_y,
	input  logic [W-1:0] wr_a,
	input  logic [W-1:0] wr_b,
	input  logic [W-1:0] wr_t
);

	localparam int VW = WORDS_PER_VAL * APB_DW;

	reg_region_e region;
	logic [2:0] word;
	logic access;
	logic bad_region;
	logic busy_any;	// Running or a start still in flight
	logic wr_ok;
	logic cmd_wr;
	logic [5:0] val_we;	// One per operand region
	logic [VW-1:0] rd_val;

	function automatic logic [W-1:0] put_word(input logic [W-1:0] old,
		input logic [2:0] idx, input logic [APB_DW-1:0] data);
		logic [VW-1:0] tmp;
		tmp = VW'(old);
		tmp[idx * APB_DW +: APB_DW] = data;
		return W'(tmp);	// Bits above W dropped
	endfunction

	assign region = reg_region_e'(paddr[7:5]);
	assign word = paddr[4:2];
	assign access = psel & penable;
	assign bad_region = (paddr[7:5] == 3'd7);
	assign busy_any = busy | start;

	assign pready = 1'b1;	// No wait states
	assign pslverr = access & (bad_region | (pwrite & busy_any));

	assign wr_ok = access & pwrite & ~pslverr;
	assign cmd_wr = wr_ok & (region == REG_CTRL) & (word == 3'd0);
	assign val_we = (wr_ok && region <= REG_D) ? (6'd1 << region) : 6'd0;

	always_comb begin
		case (region)
			REG_X: rd_val = VW'(reg_x);
			REG_Y: rd_val = VW'(reg_y);
			REG_A: rd_val = VW'(reg_a);
			REG_B: rd_val = VW'(reg_b);
			REG_T: rd_val = VW'(reg_t);
			REG_D: rd_val = VW'(reg_d);
			REG_CTRL: rd_val = VW'(busy);	// Bit 0 of word 0
			default: rd_val = '0;
		endcase
	end

	assign prdata = rd_val[word * APB_DW +: APB_DW];

	always_ff @(posedge clk) begin
		if (rst) begin
			start <= 1'b0;
			op <= OP_NONE;
			{reg_x, reg_y, reg_a, reg_b, reg_t, reg_d} <= '0;
		end else begin
			start <= cmd_wr;
			if (cmd_wr) op <= alu_op_e'(pwdata[1:0]);
			// Sequencer write-back wins, APB writes only land while idle
			if (we_x) reg_x <= wr_x;
			else if (val_we[REG_X]) reg_x <= put_word(reg_x, word, pwdata);
			if (we_y) reg_y <= wr_y;
			else if (val_we[REG_Y]) reg_y <= put_word(reg_y, word, pwdata);
			if (we_a) reg_a <= wr_a;
			else if (val_we[REG_A]) reg_a <= put_word(reg_a, word, pwdata);
			if (we_b) reg_b <= wr_b;
			else if (val_we[REG_B]) reg_b <= put_word(reg_b, word, pwdata);
			if (we_t) reg_t <= wr_t;
			else if (val_we[REG_T]) reg_t <= put_word(reg_t, word, pwdata);
			if (val_we[REG_D]) reg_d <= put_word(reg_d, word, pwdata);
		end
	end

endmodule

// File: verilog/ec_alu_pkg.sv
package ec_alu_pkg;

	localparam int APB_AW = 8;	// Byte address, region in bits 7:5
	localparam int APB_DW = 32;
	localparam int WORDS_PER_VAL = 8;	// Word 0 is least significant

	typedef enum logic [1:0] {
		OP_NONE   = 2'd0,	// Accepted, no work
		OP_PRECAL = 2'd1,
		OP_DIVMUL = 2'd2
	} alu_op_e;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_PRE_ADD,	// Single add/sub cycle
		ST_PRE_MUL_AB,
		ST_PRE_MUL_D,
		ST_DM_MUL_X,
		ST_DM_MUL_Y
	} alu_state_e;

	typedef enum logic [2:0] {
		REG_X = 3'd0, REG_Y = 3'd1, REG_A = 3'd2, REG_B = 3'd3,
		REG_T = 3'd4, REG_D = 3'd5, REG_CTRL = 3'd6
	} reg_region_e;

endpackage

// File: verilog/ec_alu_top.sv
`timescale 1ns/10ps

module ec_alu_top
	import ec_alu_pkg::*;
#(
	parameter int W = 255,
	parameter logic [W-1:0] Q = {W{1'b1}} - 18	// 2^255 - 19 at the default width
) (
	input  logic clk,
	input  logic rst,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [APB_AW-1:0] paddr,
	input  logic [APB_DW-1:0] pwdata,
	output logic [APB_DW-1:0] prdata,
	output logic pready,
	output logic pslverr
);

	logic start, busy;
	alu_op_e op;
	logic [W-1:0] reg_x, reg_y, reg_a, reg_b, reg_t, reg_d;
	logic we_x, we_y, we_a, we_b, we_t;
	logic [W-1:0] wr_x, wr_y, wr_a, wr_b, wr_t;
	logic mul_start, mul_done;
	logic [W-1:0] mul_a, mul_b, mul_p;
	logic [W-1:0] as, bs, sum, diff;

	apb_regs #(.W(W)) u_regs (
		.clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata,
		.prdata, .pready, .pslverr, .start, .op, .busy,
		.reg_x, .reg_y, .reg_a, .reg_b, .reg_t, .reg_d,
		.we_x, .we_y, .we_a, .we_b, .we_t,
		.wr_x, .wr_y, .wr_a, .wr_b, .wr_t
	);

	alu_seq #(.W(W), .Q(Q)) u_seq (
		.clk, .rst, .start, .op, .busy,
		.reg_x, .reg_y, .reg_a, .reg_b, .reg_t, .reg_d,
		.we_x, .we_y, .we_a, .we_b, .we_t,
		.wr_x, .wr_y, .wr_a, .wr_b, .wr_t,
		.mul_start, .mul_a, .mul_b, .mul_p, .mul_done,
		.as, .bs, .sum, .diff
	);

	mod_mul #(.W(W), .Q(Q)) u_mul (
		.clk, .rst, .mul_start, .mul_a, .mul_b, .mul_p, .mul_done
	);

	mod_addsub #(.W(W), .Q(Q)) u_addsub (
		.as, .bs, .sum, .diff
	);

endmodule

// File: verilog/mod_addsub.sv
`timescale 1ns/10ps

module mod_addsub #(
	parameter int W = 255,
	parameter logic [W-1:0] Q = {W{1'b1}} - 18
) (
	input  logic [W-1:0] as,
	input  logic [W-1:0] bs,
	output logic [W-1:0] sum,
	output logic [W-1:0] diff
);

	logic [W:0] sum_ext;	// One carry bit
	logic [W:0] sum_sub;
	logic [W:0] diff_ext;
	logic borrow;

	assign sum_ext = {1'b0, as} + {1'b0, bs};
	assign sum_sub = sum_ext - {1'b0, Q};

	// Both inputs below Q, so one subtraction of Q is enough
	assign sum = (sum_ext >= {1'b0, Q}) ? sum_sub[W-1:0] : sum_ext[W-1:0];

	assign diff_ext = {1'b0, as} - {1'b0, bs};
	assign borrow = diff_ext[W];	// as < bs
	assign diff = borrow ? (diff_ext[W-1:0] + Q) : diff_ext[W-1:0];

endmodule

// File: verilog/mod_mul.sv
`timescale 1ns/10ps

module mod_mul #(
	parameter int W = 255,
	parameter logic [W-1:0] Q = {W{1'b1}} - 18
) (
	input  logic clk,
	input  logic rst,
	input  logic mul_start,
	input  logic [W-1:0] mul_a,
	input  logic [W-1:0] mul_b,
	output logic [W-1:0] mul_p,
	output logic mul_done
);

	localparam int CW = $clog2(W + 1);

	logic [W-1:0] acc;	// Running product
	logic [W-1:0] a_reg;
	logic [W-1:0] b_reg;	// Scanned from the MSB
	logic [CW-1:0] cnt;	// Bits left to scan
	logic [W:0] dbl;
	logic [W:0] dbl_red;
	logic [W:0] add;
	logic [W:0] add_red;

	// One step of the interleaved multiply: acc = 2*acc + bit*a, mod Q
	always_comb begin
		dbl = {acc, 1'b0};
		dbl_red = (dbl >= {1'b0, Q}) ? (dbl - {1'b0, Q}) : dbl;
		add = dbl_red + (b_reg[W-1] ? {1'b0, a_reg} : '0);
		add_red = (add >= {1'b0, Q}) ? (add - {1'b0, Q}) : add;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt <= '0;
			mul_done <= 1'b0;
		end else begin
			mul_done <= (cnt == CW'(1));	// Last step this cycle
			if (mul_start) begin
				cnt <= CW'(W);
			end else if (cnt != '0) begin
				cnt <= cnt - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (mul_start) begin
			acc <= '0;
			a_reg <= mul_a;
			b_reg <= mul_b;
		end else if (cnt != '0) begin
			acc <= add_red[W-1:0];
			b_reg <= {b_reg[W-2:0], 1'b0};
		end
	end

	assign mul_p = acc;	// Held until the next start

endmodule
